// ==== design/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    // default layer sizes
    localparam int DEF_IFM_SIZE    = 6;
    localparam int DEF_KERNEL_SIZE = 3;
    localparam int DEF_IFM_DEPTH   = 2;
    localparam int DEF_NUM_UNITS   = 4;
    localparam int UNIT_LATENCY    = 2;     // multiply stage, then sum stage

    localparam int DEF_OFM_SIZE = DEF_IFM_SIZE - DEF_KERNEL_SIZE + 1;
    localparam int DEF_KK       = DEF_KERNEL_SIZE * DEF_KERNEL_SIZE;
    localparam int CHAN_W       = (DEF_IFM_DEPTH > 1) ? $clog2(DEF_IFM_DEPTH) : 1;
    localparam int UNIT_W       = (DEF_NUM_UNITS > 1) ? $clog2(DEF_NUM_UNITS) : 1;
    localparam int KIDX_W       = $clog2(DEF_IFM_DEPTH * DEF_KK);

    typedef logic signed [7:0]  data_t;
    typedef logic signed [19:0] acc_t;
    typedef data_t [DEF_KK-1:0] window_t;    // row major, top-left first

    typedef logic [$clog2(DEF_IFM_DEPTH*DEF_IFM_SIZE*DEF_IFM_SIZE)-1:0] ifm_addr_t;
    typedef logic [$clog2(DEF_OFM_SIZE*DEF_OFM_SIZE)-1:0]               ofm_addr_t;

    typedef struct packed {
        acc_t [DEF_NUM_UNITS-1:0] unit;
    } ofm_word_t;

    typedef struct packed {
        logic              pix_valid;  // a pixel rides with this tag
        logic              valid;      // window valid
        ofm_addr_t         addr;
        logic              first;
        logic              last;
        logic [CHAN_W-1:0] chan;
    } pix_tag_t;

    typedef struct packed {
        logic              we;
        logic [UNIT_W-1:0] unit_idx;
        logic [KIDX_W-1:0] kernel_idx;  // channel*K*K + position
        logic              is_bias;
        data_t             value;
    } weight_wr_t;

endpackage

`default_nettype wire

// ==== design/feature_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module feature_mem #(
    parameter type word_t = logic [7:0],
    parameter int  DEPTH  = 36
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  word_t                    wdata,
    input  logic                     re,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output word_t                    rdata
);

    word_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= wdata;
    end

    // registered read, old word on a same-address write
    always_ff @(posedge clk)
    begin
        if (re)
            rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== design/delay_line.sv ====
`timescale 1ns/10ps
`default_nettype none

module delay_line #(
    parameter type T      = logic,
    parameter int  STAGES = 1
) (
    input  logic clk,
    input  logic reset,
    input  T     din,
    output T     dout
);

    T pipe [STAGES];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < STAGES; i++)
                pipe[i] <= '0;
        end
        else
        begin
            pipe[0] <= din;
            for (int i = 1; i < STAGES; i++)
                pipe[i] <= pipe[i-1];
        end
    end

    assign dout = pipe[STAGES-1];

    a_stages: assert property (@(posedge clk) STAGES >= 1)
        else $error("delay_line: STAGES must be at least 1");

endmodule

`default_nettype wire

// ==== design/layer_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module layer_ctrl
    import conv_pkg::*;
#(
    parameter int IFM_SIZE    = DEF_IFM_SIZE,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE,
    parameter int IFM_DEPTH   = DEF_IFM_DEPTH
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      start_from_previous,
    input  logic      end_from_next,
    input  logic      done_write,
    output logic      ifm_re,
    output ifm_addr_t ifm_raddr,
    output pix_tag_t  tag,
    output logic      start_to_next,
    output logic      end_to_previous
);

    localparam int OFM_SIZE = IFM_SIZE - KERNEL_SIZE + 1;
    localparam int POS_W    = $clog2(IFM_SIZE);

    typedef enum logic [1:0] {IDLE, READ, DRAIN, WAIT_NEXT} state_t;

    state_t            state;
    state_t            state_next;
    logic [POS_W-1:0]  col_cnt;
    logic [POS_W-1:0]  row_cnt;
    logic [CHAN_W-1:0] chan_cnt;
    ifm_addr_t         addr_cnt;
    logic              col_end;
    logic              row_end;
    logic              last_pix;
    int                ofm_row;
    int                ofm_col;

    ////////////////////////////////////////////////////////////////////////////
    // layer FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (start_from_previous)
                    state_next = READ;
            READ:
                if (last_pix)
                    state_next = DRAIN;
            DRAIN:                              // pipeline still writing
                if (done_write)
                    state_next = WAIT_NEXT;
            WAIT_NEXT:                          // hold the OFM for the next layer
                if (end_from_next)
                    state_next = IDLE;
            default:
                state_next = IDLE;
        endcase
    end

    assign end_to_previous = (state == IDLE);
    assign start_to_next   = (state == WAIT_NEXT) && end_from_next;
    assign ifm_re          = (state == READ);
    assign ifm_raddr       = addr_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // pixel counters
    ////////////////////////////////////////////////////////////////////////////

    assign col_end  = (col_cnt == POS_W'(IFM_SIZE - 1));
    assign row_end  = (row_cnt == POS_W'(IFM_SIZE - 1));
    assign last_pix = col_end && row_end && (chan_cnt == CHAN_W'(IFM_DEPTH - 1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            col_cnt  <= '0;
            row_cnt  <= '0;
            chan_cnt <= '0;
            addr_cnt <= '0;
        end
        else if (state != READ)
        begin
            col_cnt  <= '0;
            row_cnt  <= '0;
            chan_cnt <= '0;
            addr_cnt <= '0;
        end
        else
        begin
            addr_cnt <= addr_cnt + 1'b1;
            if (col_end)
            begin
                col_cnt <= '0;
                if (row_end)
                begin
                    row_cnt  <= '0;
                    chan_cnt <= chan_cnt + 1'b1;
                end
                else
                    row_cnt <= row_cnt + 1'b1;
            end
            else
                col_cnt <= col_cnt + 1'b1;
        end
    end

    // window whose bottom-right pixel is being read
    assign ofm_row = int'(row_cnt) - (KERNEL_SIZE - 1);
    assign ofm_col = int'(col_cnt) - (KERNEL_SIZE - 1);

    always_comb
    begin
        tag = '0;
        if (state == READ)
        begin
            tag.pix_valid = 1'b1;
            tag.valid     = (ofm_col >= 0);     // rows are gated by the window buffer
            tag.addr      = ofm_addr_t'(ofm_row * OFM_SIZE + ofm_col);
            tag.first     = (chan_cnt == '0);
            tag.last      = (chan_cnt == CHAN_W'(IFM_DEPTH - 1));
            tag.chan      = chan_cnt;
        end
    end

    a_handoff: assert property (@(posedge clk) disable iff (reset)
        start_to_next |-> end_from_next ##1 end_to_previous)
        else $error("layer_ctrl: start_to_next without a clean handoff");

    a_done_in_drain: assert property (@(posedge clk) disable iff (reset)
        done_write |-> state == DRAIN)
        else $error("layer_ctrl: last OFM write outside DRAIN");

endmodule

`default_nettype wire

// ==== design/window_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module window_buffer
    import conv_pkg::*;
#(
    parameter int IFM_SIZE    = DEF_IFM_SIZE,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE
) (
    input  logic     clk,
    input  logic     reset,
    input  data_t    pix,
    input  pix_tag_t tag_in,
    output window_t  window,
    output pix_tag_t tag_out
);

    localparam int FIFO_SIZE = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;
    localparam int CH_PIX    = IFM_SIZE * IFM_SIZE;
    localparam int OFM_SIZE  = IFM_SIZE - KERNEL_SIZE + 1;

    data_t                     sr [FIFO_SIZE];   // sr[0] newest
    logic [$clog2(CH_PIX)-1:0] pix_cnt;          // pixels already in, this channel
    logic                      full;

    assign full = (pix_cnt >= FIFO_SIZE - 1);    // incoming pixel completes a window

    always_ff @(posedge clk)
    begin
        if (tag_in.pix_valid)
        begin
            sr[0] <= pix;
            for (int i = 1; i < FIFO_SIZE; i++)
                sr[i] <= sr[i-1];
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pix_cnt <= '0;
            tag_out <= '0;
        end
        else
        begin
            tag_out       <= tag_in;
            tag_out.valid <= tag_in.valid && tag_in.pix_valid && full;
            if (tag_in.pix_valid)
                pix_cnt <= (pix_cnt == CH_PIX - 1) ? '0 : pix_cnt + 1'b1;
        end
    end

    // taps, window row i col j
    always_comb
    begin
        for (int i = 0; i < KERNEL_SIZE; i++)
            for (int j = 0; j < KERNEL_SIZE; j++)
                window[i*KERNEL_SIZE + j] = sr[(KERNEL_SIZE-1-i)*IFM_SIZE + KERNEL_SIZE-1-j];
    end

    // the controller's OFM address must match the pixel position seen here
    a_fill: assert property (@(posedge clk) disable iff (reset)
        tag_out.valid |-> $past(pix_cnt) >= FIFO_SIZE - 1
            && tag_out.addr == ofm_addr_t'(($past(pix_cnt) / IFM_SIZE - (KERNEL_SIZE - 1))
                * OFM_SIZE + $past(pix_cnt) % IFM_SIZE - (KERNEL_SIZE - 1)))
        else $error("window_buffer: valid window before fill or at wrong address");

endmodule

`default_nettype wire

// ==== design/conv_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module conv_unit
    import conv_pkg::*;
#(
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE,
    parameter int IFM_DEPTH   = DEF_IFM_DEPTH,
    parameter int UNIT_INDEX  = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  weight_wr_t        weight_wr,
    input  window_t           window,
    input  logic [CHAN_W-1:0] channel,
    output acc_t              psum,
    output acc_t              bias
);

    localparam int KK = KERNEL_SIZE * KERNEL_SIZE;

    data_t              weights [IFM_DEPTH*KK];
    logic signed [15:0] prod [KK];
    logic               sel;
    acc_t               sum;

    assign sel = weight_wr.we && (int'(weight_wr.unit_idx) == UNIT_INDEX);

    always_ff @(posedge clk)
    begin
        if (sel && !weight_wr.is_bias)
            weights[weight_wr.kernel_idx] <= weight_wr.value;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            bias <= '0;
        else if (sel && weight_wr.is_bias)
            bias <= acc_t'(weight_wr.value);    // sign extended
    end

    // stage 1, products against this channel's kernel
    always_ff @(posedge clk)
    begin
        for (int p = 0; p < KK; p++)
            prod[p] <= window[p] * weights[int'(channel)*KK + p];
    end

    always_comb
    begin
        sum = '0;
        for (int p = 0; p < KK; p++)
            sum = sum + acc_t'(prod[p]);
    end

    // stage 2
    always_ff @(posedge clk)
    begin
        psum <= sum;
    end

endmodule

`default_nettype wire

// ==== design/psum_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

module psum_writer
    import conv_pkg::*;
#(
    parameter int NUM_UNITS = DEF_NUM_UNITS,
    parameter int OFM_SIZE  = DEF_OFM_SIZE
) (
    input  logic      clk,
    input  logic      reset,
    input  pix_tag_t  tag,
    input  ofm_word_t psums,
    input  ofm_word_t biases,
    input  ofm_word_t ofm_rdata,
    output logic      ofm_re,
    output ofm_addr_t ofm_raddr,
    output logic      ofm_we,
    output ofm_addr_t ofm_waddr,
    output ofm_word_t ofm_wdata,
    output logic      done_write
);

    pix_tag_t  tag_r;
    ofm_word_t psum_r;
    acc_t      total;

    // fetch the old partial sum
    assign ofm_re    = tag.valid;
    assign ofm_raddr = tag.addr;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            tag_r <= '0;
        else
            tag_r <= tag;
    end

    always_ff @(posedge clk)
    begin
        psum_r <= psums;
    end

    always_comb
    begin
        ofm_wdata = '0;
        total     = '0;
        for (int u = 0; u < NUM_UNITS; u++)
        begin
            total = psum_r.unit[u] + (tag_r.first ? biases.unit[u] : ofm_rdata.unit[u]);
            if (tag_r.last && total < 0)
                total = '0;                 // relu after the final channel
            ofm_wdata.unit[u] = total;
        end
    end

    assign ofm_we     = tag_r.valid;
    assign ofm_waddr  = tag_r.addr;
    assign done_write = tag_r.valid && tag_r.last
                        && (tag_r.addr == ofm_addr_t'(OFM_SIZE * OFM_SIZE - 1));

    a_waddr: assert property (@(posedge clk) disable iff (reset)
        ofm_we |-> int'(ofm_waddr) < OFM_SIZE * OFM_SIZE)
        else $error("psum_writer: OFM write address out of range");

endmodule

`default_nettype wire

// ==== design/conv_layer_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module conv_layer_top
    import conv_pkg::*;
#(
    parameter int IFM_SIZE    = DEF_IFM_SIZE,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE,
    parameter int IFM_DEPTH   = DEF_IFM_DEPTH,
    parameter int NUM_UNITS   = DEF_NUM_UNITS
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       ifm_we,
    input  ifm_addr_t  ifm_waddr,
    input  data_t      ifm_wdata,
    input  weight_wr_t weight_wr,
    input  logic       start_from_previous,
    input  logic       end_from_next,
    input  ofm_addr_t  ofm_raddr,
    output ofm_word_t  ofm_rdata,
    output logic       start_to_next,
    output logic       end_to_previous
);

    localparam int OFM_SIZE = IFM_SIZE - KERNEL_SIZE + 1;

    logic           ifm_re;
    ifm_addr_t      ifm_raddr;
    data_t          pix;
    pix_tag_t       ctrl_tag;
    pix_tag_t       mem_tag;
    pix_tag_t       win_tag;
    pix_tag_t       unit_tag;
    window_t        window;
    wire ofm_word_t psums;
    wire ofm_word_t biases;
    logic           wr_re;
    ofm_addr_t      wr_raddr;
    logic           wr_we;
    ofm_addr_t      wr_waddr;
    ofm_word_t      wr_wdata;
    logic           done_write;
    logic           mem_re;
    ofm_addr_t      mem_raddr;

    ////////////////////////////////////////////////////////////////////////////
    // memories and control
    ////////////////////////////////////////////////////////////////////////////

    feature_mem #(.word_t(data_t), .DEPTH(IFM_DEPTH*IFM_SIZE*IFM_SIZE)) ifm_mem_i (
        .clk(clk), .we(ifm_we), .waddr(ifm_waddr), .wdata(ifm_wdata),
        .re(ifm_re), .raddr(ifm_raddr), .rdata(pix));

    // writer has the read port during a run, outside reads while idle
    assign mem_raddr = wr_re ? wr_raddr : ofm_raddr;
    assign mem_re    = wr_re || end_to_previous;

    feature_mem #(.word_t(ofm_word_t), .DEPTH(OFM_SIZE*OFM_SIZE)) ofm_mem_i (
        .clk(clk), .we(wr_we), .waddr(wr_waddr), .wdata(wr_wdata),
        .re(mem_re), .raddr(mem_raddr), .rdata(ofm_rdata));

    layer_ctrl #(.IFM_SIZE(IFM_SIZE), .KERNEL_SIZE(KERNEL_SIZE), .IFM_DEPTH(IFM_DEPTH)) ctrl_i (
        .clk(clk), .reset(reset), .start_from_previous(start_from_previous),
        .end_from_next(end_from_next), .done_write(done_write), .ifm_re(ifm_re),
        .ifm_raddr(ifm_raddr), .tag(ctrl_tag), .start_to_next(start_to_next),
        .end_to_previous(end_to_previous));

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    delay_line #(.T(pix_tag_t), .STAGES(1)) mem_dly_i (
        .clk(clk), .reset(reset), .din(ctrl_tag), .dout(mem_tag));

    window_buffer #(.IFM_SIZE(IFM_SIZE), .KERNEL_SIZE(KERNEL_SIZE)) win_i (
        .clk(clk), .reset(reset), .pix(pix), .tag_in(mem_tag),
        .window(window), .tag_out(win_tag));

    delay_line #(.T(pix_tag_t), .STAGES(UNIT_LATENCY)) unit_dly_i (
        .clk(clk), .reset(reset), .din(win_tag), .dout(unit_tag));

    for (genvar g = 0; g < NUM_UNITS; g++)
    begin : g_unit
        conv_unit #(.KERNEL_SIZE(KERNEL_SIZE), .IFM_DEPTH(IFM_DEPTH), .UNIT_INDEX(g)) unit_i (
            .clk(clk), .reset(reset), .weight_wr(weight_wr), .window(window),
            .channel(win_tag.chan), .psum(psums.unit[g]), .bias(biases.unit[g]));
    end

    psum_writer #(.NUM_UNITS(NUM_UNITS), .OFM_SIZE(OFM_SIZE)) writer_i (
        .clk(clk), .reset(reset), .tag(unit_tag), .psums(psums), .biases(biases),
        .ofm_rdata(ofm_rdata), .ofm_re(wr_re), .ofm_raddr(wr_raddr), .ofm_we(wr_we),
        .ofm_waddr(wr_waddr), .ofm_wdata(wr_wdata), .done_write(done_write));

endmodule

`default_nettype wire

// ==== verification/clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== verification/conv_layer_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module conv_layer_tb
    import conv_pkg::*;
();

    localparam int IFM_SIZE     = DEF_IFM_SIZE;
    localparam int KERNEL_SIZE  = DEF_KERNEL_SIZE;
    localparam int IFM_DEPTH    = DEF_IFM_DEPTH;
    localparam int NUM_UNITS    = DEF_NUM_UNITS;
    localparam int OFM_SIZE     = IFM_SIZE - KERNEL_SIZE + 1;
    localparam int KK           = KERNEL_SIZE * KERNEL_SIZE;
    localparam int CH_PIX       = IFM_SIZE * IFM_SIZE;
    localparam int IFM_PIX      = IFM_DEPTH * CH_PIX;
    localparam int OFM_PIX      = OFM_SIZE * OFM_SIZE;
    localparam int PIPE_LAT     = 5;    // memory, window, two unit stages, writer
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 40;
    localparam int RUN_LIMIT    = IFM_PIX + 40;
    localparam int LOAD_CYCLES  = IFM_PIX + NUM_UNITS * (IFM_DEPTH * KK + 1) + 2;
    localparam int CHECK_CYCLES = 2 * OFM_PIX + 2;
    localparam int BP_CYCLES    = IFM_PIX + PIPE_LAT + 3 + 60 + 10;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + BP_CYCLES
                                    + 6 * (RUN_LIMIT + LOAD_CYCLES + CHECK_CYCLES);

    logic       clk;
    logic       reset;
    logic       ifm_we;
    ifm_addr_t  ifm_waddr;
    data_t      ifm_wdata;
    weight_wr_t weight_wr;
    logic       start_from_previous;
    logic       end_from_next;
    ofm_addr_t  ofm_raddr;
    ofm_word_t  ofm_rdata;
    logic       start_to_next;
    logic       end_to_previous;

    // reference data, one layer
    int ifm_px  [IFM_DEPTH][IFM_SIZE][IFM_SIZE];
    int wgt     [NUM_UNITS][IFM_DEPTH*KK];
    int bias_v  [NUM_UNITS];
    int exp_ofm [NUM_UNITS][OFM_PIX];

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int err_mark;
    int neg_unit;

    clk_gen #(.PERIOD_NS(CLK_PERIOD)) clk_i (.clk(clk));

    conv_layer_top #(
        .IFM_SIZE(IFM_SIZE), .KERNEL_SIZE(KERNEL_SIZE),
        .IFM_DEPTH(IFM_DEPTH), .NUM_UNITS(NUM_UNITS)
    ) dut_i (
        .clk(clk), .reset(reset), .ifm_we(ifm_we), .ifm_waddr(ifm_waddr),
        .ifm_wdata(ifm_wdata), .weight_wr(weight_wr),
        .start_from_previous(start_from_previous), .end_from_next(end_from_next),
        .ofm_raddr(ofm_raddr), .ofm_rdata(ofm_rdata), .start_to_next(start_to_next),
        .end_to_previous(end_to_previous));

    ////////////////////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input int expected, input int got);
        $display("ERR %0t %s expected %0d got %0d", $time, name, expected, got);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("%0t %s", $time, what);
        errors++;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors > err_mark)
        begin
            tests_failed++;
            $display("test %0d %s failed with %0d errors", tests_run, name, errors - err_mark);
        end
        else
            $display("test %0d %s passed", tests_run, name);
        err_mark = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // handshake rules
    ////////////////////////////////////////////////////////////////////////////

    a_leave_idle: assert property (@(posedge clk) disable iff (reset)
        end_to_previous && start_from_previous |=> !end_to_previous)
        else report_failure("layer stayed idle after a start");

    a_fall_on_start: assert property (@(posedge clk) disable iff (reset)
        $fell(end_to_previous) |-> $past(start_from_previous))
        else report_failure("layer left idle without a start");

    a_next_idle: assert property (@(posedge clk) disable iff (reset)
        start_to_next |-> end_from_next)
        else report_failure("start_to_next raised while the next layer was busy");

    a_one_pulse: assert property (@(posedge clk) disable iff (reset)
        start_to_next |=> !start_to_next && end_to_previous)
        else report_failure("start_to_next was not a single pulse back to idle");

    a_idle_after_handoff: assert property (@(posedge clk) disable iff (reset)
        $rose(end_to_previous) |-> $past(start_to_next))
        else report_failure("layer went idle without handing off");

    a_load_while_idle: assert property (@(posedge clk) disable iff (reset)
        ifm_we || weight_wr.we |-> end_to_previous)
        else report_failure("load port written while the layer was busy");

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int rand_s8();
        data_t v;
        v = data_t'($urandom);
        return int'(v);
    endfunction

    // neg_u below zero means all units random
    task automatic load_layer(input int neg_u);
        weight_wr_t w;
        for (int c = 0; c < IFM_DEPTH; c++)
            for (int y = 0; y < IFM_SIZE; y++)
                for (int x = 0; x < IFM_SIZE; x++)
                    ifm_px[c][y][x] = (neg_u >= 0) ? int'($urandom_range(127, 0)) : rand_s8();
        for (int u = 0; u < NUM_UNITS; u++)
        begin
            for (int k = 0; k < IFM_DEPTH * KK; k++)
                wgt[u][k] = (u == neg_u) ? -int'($urandom_range(128, 1)) : rand_s8();
            bias_v[u] = (u == neg_u) ? -int'($urandom_range(128, 1)) : rand_s8();
        end
        for (int a = 0; a < IFM_PIX; a++)
        begin
            @(posedge clk);
            ifm_we    <= 1'b1;
            ifm_waddr <= ifm_addr_t'(a);
            ifm_wdata <= data_t'(ifm_px[a / CH_PIX][(a % CH_PIX) / IFM_SIZE][a % IFM_SIZE]);
        end
        @(posedge clk);
        ifm_we <= 1'b0;
        for (int u = 0; u < NUM_UNITS; u++)
            for (int k = 0; k <= IFM_DEPTH * KK; k++)
            begin
                w            = '0;
                w.we         = 1'b1;
                w.unit_idx   = UNIT_W'(u);
                w.is_bias    = (k == IFM_DEPTH * KK);
                w.kernel_idx = w.is_bias ? '0 : KIDX_W'(k);
                w.value      = data_t'(w.is_bias ? bias_v[u] : wgt[u][k]);
                @(posedge clk);
                weight_wr <= w;
            end
        @(posedge clk);
        weight_wr <= '0;
    endtask

    task automatic build_model();
        int acc;
        for (int u = 0; u < NUM_UNITS; u++)
            for (int oy = 0; oy < OFM_SIZE; oy++)
                for (int ox = 0; ox < OFM_SIZE; ox++)
                begin
                    acc = bias_v[u];
                    for (int c = 0; c < IFM_DEPTH; c++)
                        for (int i = 0; i < KERNEL_SIZE; i++)
                            for (int j = 0; j < KERNEL_SIZE; j++)
                                acc += ifm_px[c][oy+i][ox+j] * wgt[u][c*KK + i*KERNEL_SIZE + j];
                    exp_ofm[u][oy*OFM_SIZE + ox] = (acc < 0) ? 0 : acc;   // relu
                end
    endtask

    task automatic run_layer();
        int  cycles;
        bit  seen;
        cycles = 0;
        seen   = 1'b0;
        @(posedge clk);
        start_from_previous <= 1'b1;
        @(posedge clk);
        start_from_previous <= 1'b0;
        while (!seen && cycles < RUN_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            if (start_to_next)
                seen = 1'b1;
            else
                assert (!end_to_previous)
                else report_mismatch("end_to_previous", 0, 1);
        end
        if (!seen)
            report_failure("no start_to_next within the run limit");
        @(posedge clk);
    endtask

    task automatic back_pressure_run();
        int hold;
        int busy;
        int pulses;
        hold   = $urandom_range(60, 20);
        busy   = IFM_PIX + PIPE_LAT + 3;
        pulses = 0;
        @(posedge clk);
        end_from_next       <= 1'b0;
        start_from_previous <= 1'b1;
        @(posedge clk);
        start_from_previous <= 1'b0;
        for (int i = 0; i < busy + hold; i++)
        begin
            @(posedge clk);
            start_from_previous <= (i == busy + hold / 2);    // stray start in WAIT_NEXT
            @(negedge clk);
            if (start_to_next)
                pulses++;
            assert (!end_to_previous)
            else report_mismatch("end_to_previous", 0, 1);
        end
        assert (pulses == 0)
        else report_mismatch("start_to_next pulses while held", 0, pulses);
        @(posedge clk);
        start_from_previous <= 1'b0;
        end_from_next       <= 1'b1;
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk);
            if (start_to_next)
                pulses++;
            if (i > 0)
                assert (end_to_previous)
                else report_mismatch("end_to_previous", 1, 0);
        end
        assert (pulses == 1)
        else report_mismatch("start_to_next pulses after release", 1, pulses);
    endtask

    task automatic check_ofm();
        ofm_word_t got;
        for (int a = 0; a < OFM_PIX; a++)
        begin
            @(posedge clk);
            ofm_raddr <= ofm_addr_t'(a);
            @(posedge clk);
            @(negedge clk);
            got = ofm_rdata;
            for (int u = 0; u < NUM_UNITS; u++)
                assert (got.unit[u] === acc_t'(exp_ofm[u][a]))
                else report_mismatch($sformatf("ofm_rdata.unit[%0d] addr %0d", u, a),
                                     exp_ofm[u][a], int'(got.unit[u]));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        void'($urandom(97817));
        reset               = 1'b1;
        ifm_we              = 1'b0;
        ifm_waddr           = '0;
        ifm_wdata           = '0;
        weight_wr           = '0;
        start_from_previous = 1'b0;
        end_from_next       = 1'b1;
        ofm_raddr           = '0;
        err_mark            = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        assert (end_to_previous === 1'b1)
        else report_mismatch("end_to_previous", 1, int'(end_to_previous));
        assert (start_to_next === 1'b0)
        else report_mismatch("start_to_next", 0, int'(start_to_next));
        close_test("reset state");

        load_layer(-1);
        build_model();
        run_layer();
        check_ofm();
        close_test("random layer");

        neg_unit = $urandom_range(NUM_UNITS - 1, 0);
        load_layer(neg_unit);
        build_model();
        run_layer();
        check_ofm();
        close_test("relu clamp");

        load_layer(-1);
        build_model();
        back_pressure_run();
        check_ofm();
        close_test("back-pressure");

        repeat (3)
        begin
            load_layer(-1);
            build_model();
            run_layer();
            check_ofm();
        end
        close_test("back-to-back runs");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run did not finish", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
design/conv_pkg.sv
design/feature_mem.sv
design/delay_line.sv
design/layer_ctrl.sv
design/window_buffer.sv
design/conv_unit.sv
design/psum_writer.sv
design/conv_layer_top.sv
verification/clk_gen.sv
verification/conv_layer_tb.sv

// ==== Bender.yml ====
package:
  name: conv_layer

sources:
  - files:
      - design/conv_pkg.sv
      - design/feature_mem.sv
      - design/delay_line.sv
      - design/layer_ctrl.sv
      - design/window_buffer.sv
      - design/conv_unit.sv
      - design/psum_writer.sv
      - design/conv_layer_top.sv
  - target: test
    files:
      - verification/clk_gen.sv
      - verification/conv_layer_tb.sv
